// ==== project.f ====
common/washer_pkg.sv
src/key_conditioner.sv
src/program_settings.sv
process/process_fsm.sv
process/cycle_timer.sv
src/display_scan.sv
src/washer_top.sv
verification/washer_checker.sv
verification/washer_tb.sv

// ==== Bender.yml ====
package:
  name: washer_panel

sources:
  - common/washer_pkg.sv
  - src/key_conditioner.sv
  - src/program_settings.sv
  - process/process_fsm.sv
  - process/cycle_timer.sv
  - src/display_scan.sv
  - src/washer_top.sv
  - target: test
    files:
      - verification/washer_checker.sv
      - verification/washer_tb.sv

// ==== verification/washer_tb.sv ====
`timescale 1ns/1ps

module washer_tb import washer_pkg::*; ();

    localparam int CLK_PER_SEC     = 20;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int HOLD            = DEBOUNCE_CYCLES + 4;
    localparam int NUM_EDITS       = 40;
    localparam int NUM_PRESETS     = 6;
    localparam int PHASE_CYCLES    = SECS_PER_MIN * CLK_PER_SEC;   // One minute

    // Cycle budgets of the tests
    localparam int BUDGET_RESET  = 200;
    localparam int BUDGET_EDIT   = NUM_EDITS * 120;
    localparam int BUDGET_PRESET = NUM_PRESETS * 250;
    localparam int BUDGET_RUN    = 200 * 2 * HOLD + 3 * PHASE_CYCLES;
    localparam int BUDGET_PAUSE  = 6 * PHASE_CYCLES;
    localparam int BUDGET_TOTAL  = BUDGET_RESET + BUDGET_EDIT + BUDGET_PRESET
                                 + BUDGET_RUN + BUDGET_PAUSE;
    localparam int WATCHDOG_NS   = BUDGET_TOTAL * 12 / 10 * 100;

    localparam int K_UP    = 0;
    localparam int K_DOWN  = 1;
    localparam int K_LEFT  = 2;
    localparam int K_RIGHT = 3;
    localparam int K_MID   = 4;

    logic       clk = 1'b0;
    logic       rst_n;
    buttons_t   buttons;
    logic       door;
    logic [2:0] preset_sw;
    logic [3:0] ssd_ctrl;
    segments_t  ssd_out;
    logic [2:0] led_water;
    logic [2:0] led_temp;
    logic [2:0] led_mode;
    logic [1:0] led_state;

    // Model, program fields indexed by item: wash, dry, water, temp
    int m_prog [4];
    int m_item;
    int m_phase;                                      // 0 idle, 1 wash, 2 paused
    int presets [3][4] = '{'{30, 30, 1, 1}, '{15, 15, 2, 2}, '{60, 60, 3, 3}};
    int tests  = 0;
    int failed = 0;

    always #50 clk = ~clk;

    washer_top #(.CLK_PER_SEC(CLK_PER_SEC), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_washer_top (
        .clk(clk), .rst_n(rst_n), .buttons(buttons), .door(door), .preset_sw(preset_sw),
        .ssd_ctrl(ssd_ctrl), .ssd_out(ssd_out), .led_water(led_water),
        .led_temp(led_temp), .led_mode(led_mode), .led_state(led_state));

    washer_checker i_checker (
        .clk(clk), .ssd_ctrl(ssd_ctrl), .ssd_out(ssd_out), .led_water(led_water),
        .led_temp(led_temp), .led_mode(led_mode), .led_state(led_state));

    function automatic logic [2:0] one_hot(int lvl);
        return 3'(1 << (lvl - 1));
    endfunction

    function automatic logic [2:0] mode_led();
        logic [2:0] m;
        for (int k = 0; k < 3; k++)
        begin
            m[k] = 1'b1;
            for (int f = 0; f < 4; f++)
                if (m_prog[f] != presets[k][f])
                    m[k] = 1'b0;
        end
        return m;
    endfunction

    function automatic int state_led();
        return (m_phase == 0) ? 0 : 2;
    endfunction

    // Inputs change 10 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic model_key(input int b);
        int lo;
        int hi;
        lo = (m_item < 2) ? 0 : LEVEL_MIN;
        hi = (m_item < 2) ? MAX_MINUTES : LEVEL_MAX;
        if (m_phase == 0)
        begin
            case (b)
                K_UP:    m_item = (m_item + 1) % 4;
                K_DOWN:  m_item = (m_item + 3) % 4;
                K_LEFT:
                    if (m_prog[m_item] > lo)
                        m_prog[m_item]--;
                K_RIGHT:
                    if (m_prog[m_item] < hi)
                        m_prog[m_item]++;
                default: ;
            endcase
        end
    endtask

    task automatic press_key(input int b);
        step(1);                                      // Checker waits end on a falling edge
        buttons = buttons_t'(5'b10000 >> b);
        step(HOLD);
        buttons = '0;
        step(HOLD);
        model_key(b);
    endtask

    task automatic flip_switch(input int k);
        step(1);
        preset_sw[k] = 1'b1;
        step(HOLD);
        preset_sw[k] = 1'b0;
        step(HOLD);
        if (m_phase == 0)
            for (int f = 0; f < 4; f++)
                m_prog[f] = presets[k][f];
    endtask

    task automatic set_door(input logic open);
        step(1);
        door = open;
        step(HOLD);
    endtask

    task automatic set_field(input int it, input int val);
        while (m_item != it)
            press_key(K_UP);
        while (m_prog[m_item] > val)
            press_key(K_LEFT);
        while (m_prog[m_item] < val)
            press_key(K_RIGHT);
    endtask

    task automatic check_model(input string test);
        i_checker.check_idle(test, m_item + 1, m_prog[m_item], one_hot(m_prog[2]),
                             one_hot(m_prog[3]), mode_led());
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (i_checker.errors == err_before)
            $display("test %s: ok", name);
        else
        begin
            failed++;
            $display("test %s: %0d errors", name, i_checker.errors - err_before);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    initial
    begin
        int e0;
        int b;
        int k;
        int choice;
        int t1;
        int t2;
        int t3;
        void'($urandom(86));
        rst_n     = 1'b0;
        buttons   = '0;
        door      = 1'b0;
        preset_sw = '0;
        for (int f = 0; f < 4; f++)
            m_prog[f] = presets[0][f];
        m_item  = 0;
        m_phase = 0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;

        e0 = i_checker.errors;
        check_model("reset");
        end_test("reset", e0);

        e0 = i_checker.errors;
        repeat (NUM_EDITS)
        begin
            b = $urandom % 4;
            press_key(b);
            check_model("random_edit");
        end
        end_test("random_edit", e0);

        e0 = i_checker.errors;
        repeat (NUM_PRESETS)
        begin
            k = $urandom % 3;
            flip_switch(k);
            check_model("presets");
            repeat ($urandom % 4)
                press_key(K_UP);
            b = (m_prog[m_item] == ((m_item < 2) ? MAX_MINUTES : LEVEL_MAX)) ? K_LEFT : K_RIGHT;
            press_key(b);
            check_model("presets");
        end
        end_test("presets", e0);

        e0 = i_checker.errors;
        set_field(0, 1);
        set_field(1, 1);
        fork
            press_key(K_MID);
            begin
                i_checker.time_phase("full_run", 2'b10, PHASE_CYCLES, CLK_PER_SEC);
                i_checker.time_phase("full_run", 2'b01, PHASE_CYCLES, CLK_PER_SEC);
            end
        join
        check_model("full_run");
        end_test("full_run", e0);

        e0 = i_checker.errors;
        press_key(K_MID);
        m_phase = 1;
        i_checker.check_value("pause_door", "led_state", state_led(), led_state);
        step(100 + $urandom % 300);
        choice = $urandom % 2;
        if (choice == 1)
            set_door(1'b1);
        else
            press_key(K_MID);
        m_phase = 2;
        i_checker.check_value("pause_door", "led_state", state_led(), led_state);
        i_checker.next_frame("pause_door", t1);
        step(100 + $urandom % 200);
        flip_switch(2);                                // Ignored while paused
        press_key(K_RIGHT);
        i_checker.check_value("pause_door", "led_mode", mode_led(), led_mode);
        i_checker.check_value("pause_door", "led_water", one_hot(m_prog[2]), led_water);
        i_checker.next_frame("pause_door", t2);
        i_checker.check_value("pause_door", "frozen time", t1, t2);
        if (choice == 1)
        begin
            press_key(K_MID);                          // Door still open
            i_checker.check_value("pause_door", "led_state", state_led(), led_state);
            i_checker.next_frame("pause_door", t2);
            i_checker.check_value("pause_door", "time with door open", t1, t2);
            set_door(1'b0);
        end
        press_key(K_MID);
        m_phase = 1;
        step(100);
        i_checker.next_frame("pause_door", t3);
        i_checker.check_true("pause_door", t3 < t1, "countdown did not resume after mid");
        i_checker.wait_state("pause_door", 2'b00, 3 * PHASE_CYCLES);
        m_phase = 0;
        check_model("pause_door");
        set_door(1'b1);
        press_key(K_MID);
        step(DEBOUNCE_CYCLES + 3);
        i_checker.check_value("pause_door", "led_state", state_led(), led_state);
        set_door(1'b0);
        end_test("pause_door", e0);

        $display("tests: %0d  failed: %0d  checks: %0d  errors: %0d",
                 tests, failed, i_checker.checks, i_checker.errors);
        if (failed == 0 && i_checker.errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== verification/washer_checker.sv ====
`timescale 1ns/1ps

module washer_checker import washer_pkg::*; (
    input  logic       clk,
    input  logic [3:0] ssd_ctrl,
    input  segments_t  ssd_out,
    input  logic [2:0] led_water,
    input  logic [2:0] led_temp,
    input  logic [2:0] led_mode,
    input  logic [1:0] led_state
);

    int   errors    = 0;
    int   checks    = 0;
    int   frame_seq = 0;
    int   cur   [NUM_DIGITS];
    int   held  [NUM_DIGITS] = '{-1, -1, -1, -1};
    int   frame [NUM_DIGITS];
    logic cur_dp;
    logic held_dp;
    logic frame_dp;
    int   idx;
    int   last_idx  = 0;

    function automatic int scan_index(logic [3:0] ctrl);
        case (ctrl)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;
        endcase
    endfunction

    // Plain gfedcba decode, active low
    function automatic int seg_digit(segments_t s);
        case (s[6:0])
            7'h40:   return 0;
            7'h79:   return 1;
            7'h24:   return 2;
            7'h30:   return 3;
            7'h19:   return 4;
            7'h12:   return 5;
            7'h02:   return 6;
            7'h78:   return 7;
            7'h00:   return 8;
            7'h10:   return 9;
            7'h7F:   return 15;
            default: return 14;
        endcase
    endfunction

    function automatic int frame_secs();
        return (frame[3] * 10 + frame[2]) * SECS_PER_MIN + frame[1] * 10 + frame[0];
    endfunction

    task automatic check_value(input string test, input string what, input int exp,
                               input int act);
        checks++;
        if (exp != act)
        begin
            errors++;
            $display("CHECK FAILED %s: %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    task automatic check_true(input string test, input bit ok, input string msg);
        checks++;
        if (!ok)
        begin
            errors++;
            $display("ERROR %s: %s", test, msg);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame capture from the scanned display
    // The units digit changes on every second, so a frame whose units digit
    // is the same before and after it was read without a tick inside it
    always @(negedge clk)
    begin
        idx = scan_index(ssd_ctrl);
        if (idx < 0)
        begin
            if (!$isunknown(ssd_ctrl))
                check_true("scan", 1'b0, "digit enable is not one-hot");
        end
        else
        begin
            cur[idx] = seg_digit(ssd_out);
            if (idx == 2)
                cur_dp = !ssd_out[7];
            else if (ssd_out[7] == 1'b0)
                check_true("scan", 1'b0, "decimal point lit outside digit 2");
            if (idx == 0 && last_idx == 3)
            begin
                held[1] = cur[1];
                held[2] = cur[2];
                held[3] = cur[3];
                held_dp = cur_dp;
            end
            if (idx == 1 && last_idx == 0)
            begin
                if (cur[0] == held[0])
                begin
                    frame     = held;
                    frame_dp  = held_dp;
                    frame_seq = frame_seq + 1;
                end
                held[0] = cur[0];
            end
            last_idx = idx;
        end
    end

    // Second new frame is read entirely after the call
    task automatic next_frame(input string test, output int secs);
        int start;
        int n;
        start = frame_seq;
        n = 0;
        while (frame_seq < start + 2 && n < 400)
        begin
            @(negedge clk);
            n++;
        end
        check_true(test, frame_seq >= start + 2, "no steady display frame within 400 cycles");
        secs = frame_secs();
    endtask

    task automatic check_idle(input string test, input int item, input int value,
                              input logic [2:0] water, input logic [2:0] temp,
                              input logic [2:0] mode);
        int unused;
        repeat (20) @(negedge clk);
        next_frame(test, unused);
        check_value(test, "led_state", 0, led_state);
        check_value(test, "led_water", water, led_water);
        check_value(test, "led_temp", temp, led_temp);
        check_value(test, "led_mode", mode, led_mode);
        check_value(test, "item digit", item, frame[3]);
        check_value(test, "blank digit", 15, frame[2]);
        check_value(test, "value digits", value, frame[1] * 10 + frame[0]);
        check_true(test, !frame_dp, "minutes separator is lit while idle");
    endtask

    task automatic wait_state(input string test, input logic [1:0] state, input int budget);
        int n;
        n = 0;
        while (led_state != state && n < budget)
        begin
            @(negedge clk);
            n++;
        end
        check_true(test, led_state == state,
                   $sformatf("led_state did not reach %b within %0d cycles", state, budget));
    endtask

    // Length of one phase, and the shown time must not go up inside it
    task automatic time_phase(input string test, input logic [1:0] state,
                              input int exp_cycles, input int tol);
        int n;
        int prev;
        int seen;
        wait_state(test, state, 100);
        n = 0;
        prev = 1 << 20;
        seen = frame_seq;
        while (led_state == state && n <= exp_cycles + 2 * tol)
        begin
            @(negedge clk);
            n++;
            if (frame_seq != seen)
            begin
                seen = frame_seq;
                if (n > 40)                           // Skip the phase change
                begin
                    check_true(test, frame_secs() <= prev, "displayed time went up");
                    check_true(test, frame_dp, "minutes separator is dark");
                    prev = frame_secs();
                end
            end
        end
        checks++;
        if (n < exp_cycles - tol || n > exp_cycles + tol)
        begin
            errors++;
            $display("CHECK FAILED %s: cycles in state %b expected %0d +/- %0d actual %0d",
                     test, state, exp_cycles, tol, n);
        end
    endtask

endmodule

// ==== src/washer_top.sv ====
`timescale 1ns/1ps

module washer_top import washer_pkg::*; #(
    parameter int CLK_PER_SEC     = 100000000,
    parameter int DEBOUNCE_CYCLES = 1000000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  buttons_t   buttons,
    input  logic       door,
    input  logic [2:0] preset_sw,
    output logic [3:0] ssd_ctrl,
    output segments_t  ssd_out,
    output logic [2:0] led_water,
    output logic [2:0] led_temp,
    output logic [2:0] led_mode,
    output logic [1:0] led_state
);

    key_events_t events;
    logic        door_closed;
    program_t    prog;
    item_e       item;
    phase_e      phase;
    logic        timer_load;
    minutes_t    load_min;
    logic        timer_run;
    seconds_t    remaining;
    logic        expired;

    key_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_key_conditioner (
        .clk(clk), .rst_n(rst_n), .buttons(buttons), .door(door),
        .preset_sw(preset_sw), .events(events), .door_closed(door_closed));

    program_settings i_program_settings (
        .clk(clk), .rst_n(rst_n), .events(events), .phase(phase),
        .prog(prog), .item(item), .led_water(led_water),
        .led_temp(led_temp), .led_mode(led_mode));

    process_fsm i_process_fsm (
        .clk(clk), .rst_n(rst_n), .events(events), .door_closed(door_closed),
        .prog(prog), .expired(expired), .phase(phase),
        .timer_load(timer_load), .load_min(load_min), .timer_run(timer_run),
        .led_state(led_state));

    cycle_timer #(.CLK_PER_SEC(CLK_PER_SEC)) i_cycle_timer (
        .clk(clk), .rst_n(rst_n), .timer_load(timer_load), .load_min(load_min),
        .timer_run(timer_run), .remaining(remaining), .expired(expired));

    display_scan i_display_scan (
        .clk(clk), .rst_n(rst_n), .phase(phase), .item(item),
        .prog(prog), .remaining(remaining),
        .ssd_ctrl(ssd_ctrl), .ssd_out(ssd_out));

endmodule

// ==== src/display_scan.sv ====
`timescale 1ns/1ps

module display_scan import washer_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  phase_e     phase,
    input  item_e      item,
    input  program_t   prog,
    input  seconds_t   remaining,
    output logic [3:0] ssd_ctrl,      // active low
    output segments_t  ssd_out
);

    localparam int SCAN_W = $clog2(NUM_DIGITS);

    logic [SCAN_W-1:0] refresh;
    logic [SCAN_W-1:0] scan;
    digit_t            digits [NUM_DIGITS];
    minutes_t          value;         // setting under edit, 0..99
    minutes_t          run_min;
    logic [5:0]        run_sec;
    logic              dp_on;

    function automatic segments_t seg_lut(digit_t d);
        segments_t s;
        case (d)      // dp off, gfedcba active low
            4'd0:    s = 8'hC0;
            4'd1:    s = 8'hF9;
            4'd2:    s = 8'hA4;
            4'd3:    s = 8'hB0;
            4'd4:    s = 8'h99;
            4'd5:    s = 8'h92;
            4'd6:    s = 8'h82;
            4'd7:    s = 8'hF8;
            4'd8:    s = 8'h80;
            4'd9:    s = 8'h90;
            default: s = 8'hFF;
        endcase
        return s;
    endfunction

    always_comb
    begin
        case (item)
            ITEM_WASH:  value = prog.wash_min;
            ITEM_DRY:   value = prog.dry_min;
            ITEM_WATER: value = minutes_t'(prog.water);
            default:    value = minutes_t'(prog.temp);
        endcase
    end

    assign run_min = minutes_t'(remaining / SECS_PER_MIN);
    assign run_sec = 6'(remaining % SECS_PER_MIN);
    assign dp_on   = (phase != PH_IDLE);

    always_comb
    begin
        if (phase == PH_IDLE)
        begin
            digits[3] = digit_t'(item) + 4'd1;
            digits[2] = DIGIT_BLANK;
            digits[1] = digit_t'(value / 10);
            digits[0] = digit_t'(value % 10);
        end
        else
        begin
            digits[3] = digit_t'(run_min / 10);
            digits[2] = digit_t'(run_min % 10);
            digits[1] = digit_t'(run_sec / 10);
            digits[0] = digit_t'(run_sec % 10);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Digit scan
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            refresh <= '0;
            scan    <= '0;
        end
        else
        begin
            refresh <= refresh + 1'b1;
            if (refresh == SCAN_W'(NUM_DIGITS - 1))
                scan <= scan + 1'b1;
        end
    end

    assign ssd_ctrl = ~(4'b0001 << scan);

    always_comb
    begin
        ssd_out = seg_lut(digits[scan]);
        if (dp_on && scan == SCAN_W'(2))
            ssd_out[7] = 1'b0;        // Minutes/seconds separator
    end

endmodule

// ==== process/cycle_timer.sv ====
`timescale 1ns/1ps

module cycle_timer import washer_pkg::*; #(
    parameter int CLK_PER_SEC = 100000000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     timer_load,
    input  minutes_t load_min,
    input  logic     timer_run,
    output seconds_t remaining,
    output logic     expired
);

    localparam int PRE_W = $clog2(CLK_PER_SEC + 1);

    logic [PRE_W-1:0] prescale;
    logic             sec_tick;

    ////////////////////////////////////////////////////////////////////////////
    // Seconds prescaler, holds its count while paused
    assign sec_tick = timer_run && (prescale == PRE_W'(CLK_PER_SEC - 1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            prescale <= '0;
        else if (timer_load)
            prescale <= '0;                     // Full first second
        else if (timer_run)
        begin
            if (sec_tick)
                prescale <= '0;
            else
                prescale <= prescale + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Remaining time
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            remaining <= '0;
        else if (timer_load)
            remaining <= seconds_t'(load_min * SECS_PER_MIN);
        else if (sec_tick && !expired)
            remaining <= remaining - 1'b1;      // Stops at zero
    end

    assign expired = (remaining == '0);

    assert property (@(posedge clk) disable iff (!rst_n)
        remaining <= MAX_MINUTES * SECS_PER_MIN);

endmodule

// ==== process/process_fsm.sv ====
`timescale 1ns/1ps

module process_fsm import washer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  key_events_t events,
    input  logic        door_closed,
    input  program_t    prog,
    input  logic        expired,
    output phase_e      phase,
    output logic        timer_load,
    output minutes_t    load_min,
    output logic        timer_run,
    output logic [1:0]  led_state
);

    phase_e phase_next;
    logic   load_wash;
    logic   load_dry;
    logic   running;
    logic   pause_req;
    logic   resume_req;
    logic   done;

    assign running    = (phase == PH_WASH) || (phase == PH_DRY);
    assign pause_req  = events.mid || events.door_open;
    assign resume_req = events.mid && door_closed;
    assign done       = expired && !timer_load;     // Old count is stale during load

    always_comb
    begin
        phase_next = phase;
        load_wash  = 1'b0;
        load_dry   = 1'b0;
        case (phase)
            PH_IDLE:
                if (resume_req)
                begin
                    phase_next = PH_WASH;
                    load_wash  = 1'b1;
                end
            PH_WASH:
                if (pause_req)
                    phase_next = PH_WASH_PAUSE;
                else if (done)
                begin
                    phase_next = PH_DRY;
                    load_dry   = 1'b1;
                end
            PH_WASH_PAUSE: if (resume_req) phase_next = PH_WASH;
            PH_DRY:
                if (pause_req)
                    phase_next = PH_DRY_PAUSE;
                else if (done)
                    phase_next = PH_IDLE;
            PH_DRY_PAUSE:  if (resume_req) phase_next = PH_DRY;
            default:       phase_next = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase      <= PH_IDLE;
            timer_load <= 1'b0;
        end
        else
        begin
            phase      <= phase_next;
            timer_load <= load_wash || load_dry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_wash || load_dry)
            load_min <= load_wash ? prog.wash_min : prog.dry_min;
    end

    assign timer_run = running && !timer_load;

    assign led_state[1] = (phase == PH_WASH) || (phase == PH_WASH_PAUSE);
    assign led_state[0] = (phase == PH_DRY) || (phase == PH_DRY_PAUSE);

    // Opening the door stops a run on the next edge
    assert property (@(posedge clk) disable iff (!rst_n)
        (running && !door_closed) |=> !running);

endmodule

// ==== src/program_settings.sv ====
`timescale 1ns/1ps

module program_settings import washer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  key_events_t events,
    input  phase_e      phase,
    output program_t    prog,
    output item_e       item,
    output logic [2:0]  led_water,
    output logic [2:0]  led_temp,
    output logic [2:0]  led_mode
);

    function automatic minutes_t step_min(minutes_t m, logic inc);
        minutes_t r;
        r = m;
        if (inc && m != MAX_MINUTES)
            r = m + 1'b1;
        else if (!inc && m != 0)
            r = m - 1'b1;
        return r;
    endfunction

    function automatic level_t step_level(level_t l, logic inc);
        level_t r;
        r = l;
        if (inc && l != LEVEL_MAX)
            r = l + 1'b1;
        else if (!inc && l != LEVEL_MIN)
            r = l - 1'b1;
        return r;
    endfunction

    function automatic logic [2:0] level_led(level_t l);
        logic [2:0] led;
        case (l)
            2'd1:    led = 3'b001;
            2'd2:    led = 3'b010;
            2'd3:    led = 3'b100;
            default: led = 3'b000;
        endcase
        return led;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Editing, locked once a run has started
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            prog <= PRESET_STANDARD;
            item <= ITEM_WASH;
        end
        else if (phase == PH_IDLE)
        begin
            if (events.preset[0])
                prog <= PRESET_STANDARD;
            else if (events.preset[1])
                prog <= PRESET_QUICK;
            else if (events.preset[2])
                prog <= PRESET_HEAVY;
            else if (events.right || events.left)
            begin
                case (item)   // right raises, left lowers
                    ITEM_WASH:  prog.wash_min <= step_min(prog.wash_min, events.right);
                    ITEM_DRY:   prog.dry_min  <= step_min(prog.dry_min, events.right);
                    ITEM_WATER: prog.water    <= step_level(prog.water, events.right);
                    default:    prog.temp     <= step_level(prog.temp, events.right);
                endcase
            end

            if (events.up)
                item <= item_e'(item + 2'd1);             // Wraps 4 -> 1
            else if (events.down)
                item <= item_e'(item - 2'd1);
        end
    end

    assign led_water = level_led(prog.water);
    assign led_temp  = level_led(prog.temp);

    assign led_mode[0] = (prog == PRESET_STANDARD);
    assign led_mode[1] = (prog == PRESET_QUICK);
    assign led_mode[2] = (prog == PRESET_HEAVY);

    assert property (@(posedge clk) disable iff (!rst_n)
        prog.water inside {[LEVEL_MIN:LEVEL_MAX]} &&
        prog.temp inside {[LEVEL_MIN:LEVEL_MAX]});

endmodule

// ==== src/key_conditioner.sv ====
`timescale 1ns/1ps

module key_conditioner import washer_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 1000000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  buttons_t    buttons,
    input  logic        door,         // high while open
    input  logic [2:0]  preset_sw,
    output key_events_t events,
    output logic        door_closed
);

    localparam int NUM_DEB = 6;
    localparam int CNT_W   = $clog2(DEBOUNCE_CYCLES + 1);

    logic [NUM_DEB-1:0] raw_q;        // {door, up, down, left, right, mid}
    logic [NUM_DEB-1:0] stable;
    logic [NUM_DEB-1:0] stable_q;
    logic [CNT_W-1:0]   cnt [NUM_DEB];
    logic [2:0]         sw_q;
    logic [2:0]         sw_prev;
    logic [NUM_DEB-1:0] rise;
    logic               door_fall;

    ////////////////////////////////////////////////////////////////////////////
    // Input sampling and debounce
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            raw_q    <= '0;
            stable   <= '0;
            stable_q <= '0;
            sw_q     <= '0;
            sw_prev  <= '0;
            for (int i = 0; i < NUM_DEB; i++)
                cnt[i] <= '0;
        end
        else
        begin
            raw_q    <= {door, buttons};
            stable_q <= stable;
            sw_q     <= preset_sw;
            sw_prev  <= sw_q;
            for (int i = 0; i < NUM_DEB; i++)
            begin
                if (raw_q[i] == stable[i])
                    cnt[i] <= '0;                         // Bounce restarts the count
                else if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1))
                begin
                    stable[i] <= raw_q[i];
                    cnt[i]    <= '0;
                end
                else
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign rise      = stable & ~stable_q;
    assign door_fall = ~stable[5] & stable_q[5];

    // Door level registered so it lines up with the door pulses
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            events      <= '0;
            door_closed <= 1'b1;
        end
        else
        begin
            events <= '{up: rise[4], down: rise[3], left: rise[2], right: rise[1],
                        mid: rise[0], door_open: rise[5], door_close: door_fall,
                        preset: sw_q & ~sw_prev};
            door_closed <= ~stable[5];
        end
    end

    // No event pulse stays high into a second cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (events & $past(events)) == '0);

endmodule

// ==== common/washer_pkg.sv ====
package washer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Limits
    localparam int MAX_MINUTES  = 99;
    localparam int SECS_PER_MIN = 60;
    localparam int NUM_DIGITS   = 4;
    localparam int LEVEL_MIN    = 1;
    localparam int LEVEL_MAX    = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    typedef logic [6:0]  minutes_t;
    typedef logic [12:0] seconds_t;    // up to 99 min of seconds
    typedef logic [1:0]  level_t;
    typedef logic [3:0]  digit_t;
    typedef logic [7:0]  segments_t;   // active low, dp in bit 7

    localparam digit_t DIGIT_BLANK = 4'd15;

    // Raw push buttons
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic mid;
    } buttons_t;

    // One-cycle pulses out of the input conditioner
    typedef struct packed {
        logic       up;
        logic       down;
        logic       left;
        logic       right;
        logic       mid;
        logic       door_open;
        logic       door_close;
        logic [2:0] preset;     // standard, quick, heavy
    } key_events_t;

    typedef struct packed {
        minutes_t wash_min;
        minutes_t dry_min;
        level_t   water;
        level_t   temp;
    } program_t;

    typedef enum logic [1:0] {ITEM_WASH, ITEM_DRY, ITEM_WATER, ITEM_TEMP} item_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_WASH,
        PH_WASH_PAUSE,
        PH_DRY,
        PH_DRY_PAUSE
    } phase_e;

    localparam program_t PRESET_STANDARD = '{wash_min: 7'd30, dry_min: 7'd30,
                                             water: 2'd1, temp: 2'd1};
    localparam program_t PRESET_QUICK    = '{wash_min: 7'd15, dry_min: 7'd15,
                                             water: 2'd2, temp: 2'd2};
    localparam program_t PRESET_HEAVY    = '{wash_min: 7'd60, dry_min: 7'd60,
                                             water: 2'd3, temp: 2'd3};

endpackage
